/* common/lsu_pkg.sv */
package lsu_pkg;

  // ------------------------------------------------------------
  // widths
  // ------------------------------------------------------------
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned BeWidth      = 4;
  localparam int unsigned TransIdWidth = 3;
  localparam int unsigned CauseWidth   = 4;

  // ------------------------------------------------------------
  // types
  // ------------------------------------------------------------
  typedef logic [DataWidth-1:0]    word_t;
  typedef logic [DataWidth-1:0]    addr_t;
  typedef logic [BeWidth-1:0]      be_t;
  typedef logic [TransIdWidth-1:0] trans_id_t;
  typedef logic [CauseWidth-1:0]   exc_cause_t;

  // exception cause codes
  localparam exc_cause_t CauseLdMisaligned = 4'd4;
  localparam exc_cause_t CauseStMisaligned = 4'd6;

  // loads first, then stores
  typedef enum logic [2:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  // both units walk the same four-phase sequence
  typedef enum logic [1:0] {
    IDLE,
    REQ,
    RELEASE,
    DONE
  } mem_state_e;

  typedef mem_state_e load_state_e;
  typedef mem_state_e store_state_e;

endpackage

/* load_store/load_unit.sv */
`timescale 1ns/1ns

module load_unit
  import lsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       valid_i,
  input  addr_t      addr_i,
  input  be_t        be_i,
  input  lsu_op_e    op_i,
  input  trans_id_t  trans_id_i,
  input  logic       misaligned_i,
  input  logic       mem_ack_i,
  input  word_t      mem_rdata_i,
  output logic       ready_o,
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  output be_t        mem_be_o,
  output logic       load_valid_o,
  output trans_id_t  load_trans_id_o,
  output word_t      load_result_o,
  output logic       load_exc_o,
  output exc_cause_t load_cause_o
);

  load_state_e state_q;
  load_state_e state_d;
  lsu_op_e     op_q;
  word_t       rdata_q;
  logic        misaligned_q;
  logic [7:0]  sel_byte;
  logic [15:0] sel_half;
  word_t       ext_data;

  // ------------------------------------------------------------
  // four-phase handshake FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (valid_i) state_d = misaligned_i ? DONE : REQ;
      REQ:     if (mem_ack_i) state_d = RELEASE;
      RELEASE: if (!mem_ack_i) state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && valid_i) begin
      mem_addr_o      <= addr_i;
      mem_be_o        <= be_i;
      op_q            <= op_i;
      load_trans_id_o <= trans_id_i;
      misaligned_q    <= misaligned_i;
    end
    // read word is captured with the ack
    if (state_q == REQ && mem_ack_i) begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign ready_o      = (state_q == IDLE);
  assign mem_req_o    = (state_q == REQ);
  assign load_valid_o = (state_q == DONE);

  // ------------------------------------------------------------
  // lane select and extension
  // ------------------------------------------------------------
  always_comb begin
    case (mem_addr_o[1:0])
      2'd0:    sel_byte = rdata_q[7:0];
      2'd1:    sel_byte = rdata_q[15:8];
      2'd2:    sel_byte = rdata_q[23:16];
      default: sel_byte = rdata_q[31:24];
    endcase
    sel_half = mem_addr_o[1] ? rdata_q[31:16] : rdata_q[15:0];
    case (op_q)
      LB:      ext_data = {{24{sel_byte[7]}}, sel_byte};
      LBU:     ext_data = {24'b0, sel_byte};
      LH:      ext_data = {{16{sel_half[15]}}, sel_half};
      LHU:     ext_data = {16'b0, sel_half};
      default: ext_data = rdata_q;
    endcase
  end

  // a faulting load reports its address instead of data
  assign load_result_o = misaligned_q ? mem_addr_o : ext_data;
  assign load_exc_o    = misaligned_q;
  assign load_cause_o  = misaligned_q ? CauseLdMisaligned : exc_cause_t'(0);

endmodule

/* load_store/store_unit.sv */
`timescale 1ns/1ns

module store_unit
  import lsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  logic       valid_i,
  input  addr_t      addr_i,
  input  be_t        be_i,
  input  trans_id_t  trans_id_i,
  input  word_t      wdata_i,
  input  logic       misaligned_i,
  input  logic       mem_ack_i,
  output logic       ready_o,
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  output be_t        mem_be_o,
  output word_t      mem_wdata_o,
  output logic       store_valid_o,
  output trans_id_t  store_trans_id_o,
  output logic       store_exc_o,
  output exc_cause_t store_cause_o
);

  store_state_e state_q;
  store_state_e state_d;
  word_t        lane_data;
  logic         misaligned_q;

  // low byte or half moves up to the addressed lane
  assign lane_data = wdata_i << {addr_i[1:0], 3'b000};

  // ------------------------------------------------------------
  // four-phase handshake FSM
  // ------------------------------------------------------------
  always_comb begin
    state_d = state_q;
    case (state_q)
      IDLE:    if (valid_i) state_d = misaligned_i ? DONE : REQ;
      REQ:     if (mem_ack_i) state_d = RELEASE;
      RELEASE: if (!mem_ack_i) state_d = DONE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  always_ff @(posedge clk_i) begin
    if (state_q == IDLE && valid_i) begin
      mem_addr_o       <= addr_i;
      mem_be_o         <= be_i;
      mem_wdata_o      <= lane_data;
      store_trans_id_o <= trans_id_i;
      misaligned_q     <= misaligned_i;
    end
  end

  assign ready_o       = (state_q == IDLE);
  assign mem_req_o     = (state_q == REQ);
  assign store_valid_o = (state_q == DONE);
  assign store_exc_o   = misaligned_q;
  assign store_cause_o = misaligned_q ? CauseStMisaligned : exc_cause_t'(0);

endmodule

/* load_store_unit.f */
common/lsu_pkg.sv
source/lsu_issue.sv
load_store/load_unit.sv
load_store/store_unit.sv
source/mem_arbiter.sv
source/load_store_unit.sv
verification/mem_model.sv
verification/tb_load_store_unit.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -j 0 --Mdir obj_dir \
  --top-module tb_load_store_unit -f load_store_unit.f \
  && ./obj_dir/Vtb_load_store_unit > sim.log 2>&1

cat sim.log 2>/dev/null
grep -qx "TEST OK" sim.log && echo "simulation passed" || { echo "simulation failed"; exit 1; }

/* source/load_store_unit.sv */
`timescale 1ns/1ns

module load_store_unit
  import lsu_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  // issue
  input  logic       valid_i,
  output logic       ready_o,
  input  lsu_op_e    op_i,
  input  word_t      operand_a_i,
  input  word_t      imm_i,
  input  word_t      wdata_i,
  input  trans_id_t  trans_id_i,
  // load result
  output logic       load_valid_o,
  output trans_id_t  load_trans_id_o,
  output word_t      load_result_o,
  output logic       load_exc_o,
  output exc_cause_t load_cause_o,
  // store result
  output logic       store_valid_o,
  output trans_id_t  store_trans_id_o,
  output logic       store_exc_o,
  output exc_cause_t store_cause_o,
  // memory
  output logic       mem_req_o,
  output addr_t      mem_addr_o,
  output logic       mem_we_o,
  output be_t        mem_be_o,
  output word_t      mem_wdata_o,
  input  logic       mem_ack_i,
  input  word_t      mem_rdata_i
);

  logic      ld_valid;
  logic      ld_ready;
  logic      st_valid;
  logic      st_ready;
  addr_t     req_addr;
  be_t       req_be;
  lsu_op_e   req_op;
  word_t     req_wdata;
  trans_id_t req_trans_id;
  logic      req_misaligned;

  logic      ld_mem_req;
  logic      ld_mem_ack;
  addr_t     ld_mem_addr;
  be_t       ld_mem_be;
  word_t     ld_mem_rdata;
  logic      st_mem_req;
  logic      st_mem_ack;
  addr_t     st_mem_addr;
  be_t       st_mem_be;
  word_t     st_mem_wdata;

  lsu_issue u_issue (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (valid_i),
    .op_i            (op_i),
    .operand_a_i     (operand_a_i),
    .imm_i           (imm_i),
    .wdata_i         (wdata_i),
    .trans_id_i      (trans_id_i),
    .ld_ready_i      (ld_ready),
    .st_ready_i      (st_ready),
    .ready_o         (ready_o),
    .ld_valid_o      (ld_valid),
    .st_valid_o      (st_valid),
    .req_addr_o      (req_addr),
    .req_be_o        (req_be),
    .req_op_o        (req_op),
    .req_wdata_o     (req_wdata),
    .req_trans_id_o  (req_trans_id),
    .req_misaligned_o(req_misaligned)
  );

  load_unit u_load (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .valid_i        (ld_valid),
    .addr_i         (req_addr),
    .be_i           (req_be),
    .op_i           (req_op),
    .trans_id_i     (req_trans_id),
    .misaligned_i   (req_misaligned),
    .mem_ack_i      (ld_mem_ack),
    .mem_rdata_i    (ld_mem_rdata),
    .ready_o        (ld_ready),
    .mem_req_o      (ld_mem_req),
    .mem_addr_o     (ld_mem_addr),
    .mem_be_o       (ld_mem_be),
    .load_valid_o   (load_valid_o),
    .load_trans_id_o(load_trans_id_o),
    .load_result_o  (load_result_o),
    .load_exc_o     (load_exc_o),
    .load_cause_o   (load_cause_o)
  );

  store_unit u_store (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (st_valid),
    .addr_i          (req_addr),
    .be_i            (req_be),
    .trans_id_i      (req_trans_id),
    .wdata_i         (req_wdata),
    .misaligned_i    (req_misaligned),
    .mem_ack_i       (st_mem_ack),
    .ready_o         (st_ready),
    .mem_req_o       (st_mem_req),
    .mem_addr_o      (st_mem_addr),
    .mem_be_o        (st_mem_be),
    .mem_wdata_o     (st_mem_wdata),
    .store_valid_o   (store_valid_o),
    .store_trans_id_o(store_trans_id_o),
    .store_exc_o     (store_exc_o),
    .store_cause_o   (store_cause_o)
  );

  mem_arbiter u_arb (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .ld_mem_req_i  (ld_mem_req),
    .ld_mem_addr_i (ld_mem_addr),
    .ld_mem_be_i   (ld_mem_be),
    .ld_mem_ack_o  (ld_mem_ack),
    .ld_mem_rdata_o(ld_mem_rdata),
    .st_mem_req_i  (st_mem_req),
    .st_mem_addr_i (st_mem_addr),
    .st_mem_be_i   (st_mem_be),
    .st_mem_wdata_i(st_mem_wdata),
    .st_mem_ack_o  (st_mem_ack),
    .mem_req_o     (mem_req_o),
    .mem_addr_o    (mem_addr_o),
    .mem_we_o      (mem_we_o),
    .mem_be_o      (mem_be_o),
    .mem_wdata_o   (mem_wdata_o),
    .mem_ack_i     (mem_ack_i),
    .mem_rdata_i   (mem_rdata_i)
  );

endmodule

/* source/lsu_issue.sv */
`timescale 1ns/1ns

module lsu_issue
  import lsu_pkg::*;
(
  input  logic      clk_i,
  input  logic      rst_ni,
  input  logic      valid_i,
  input  lsu_op_e   op_i,
  input  word_t     operand_a_i,
  input  word_t     imm_i,
  input  word_t     wdata_i,
  input  trans_id_t trans_id_i,
  input  logic      ld_ready_i,
  input  logic      st_ready_i,
  output logic      ready_o,
  output logic      ld_valid_o,
  output logic      st_valid_o,
  output addr_t     req_addr_o,
  output be_t       req_be_o,
  output lsu_op_e   req_op_o,
  output word_t     req_wdata_o,
  output trans_id_t req_trans_id_o,
  output logic      req_misaligned_o
);

  addr_t agu_addr;
  be_t   agu_be;
  logic  agu_misaligned;
  logic  valid_q;
  logic  active_q;
  logic  is_load;
  logic  take;

  // ------------------------------------------------------------
  // address generation, byte enable, alignment
  // ------------------------------------------------------------
  assign agu_addr = operand_a_i + imm_i;

  always_comb begin
    agu_be         = 4'b1111;
    agu_misaligned = 1'b0;
    case (op_i)
      LB, LBU, SB: agu_be = be_t'(4'b0001 << agu_addr[1:0]);
      LH, LHU, SH: begin
        agu_be         = be_t'(4'b0011 << agu_addr[1:0]);
        agu_misaligned = agu_addr[0];
      end
      default: begin
        agu_be         = 4'b1111;
        agu_misaligned = |agu_addr[1:0];
      end
    endcase
  end

  // ------------------------------------------------------------
  // one-entry request register
  // ------------------------------------------------------------
  assign is_load    = !(req_op_o inside {SB, SH, SW});
  assign ld_valid_o = valid_q & is_load;
  assign st_valid_o = valid_q & ~is_load;
  assign take       = (ld_valid_o & ld_ready_i) | (st_valid_o & st_ready_i);
  // no requests in the first cycle out of reset
  assign ready_o    = active_q & (~valid_q | take);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q  <= 1'b0;
      active_q <= 1'b0;
    end else begin
      active_q <= 1'b1;
      if (valid_i && ready_o) begin
        valid_q <= 1'b1;
      end else if (take) begin
        valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      req_addr_o       <= agu_addr;
      req_be_o         <= agu_be;
      req_op_o         <= op_i;
      req_wdata_o      <= wdata_i;
      req_trans_id_o   <= trans_id_i;
      req_misaligned_o <= agu_misaligned;
    end
  end

endmodule

/* source/mem_arbiter.sv */
`timescale 1ns/1ns

module mem_arbiter
  import lsu_pkg::*;
(
  input  logic  clk_i,
  input  logic  rst_ni,
  // load path
  input  logic  ld_mem_req_i,
  input  addr_t ld_mem_addr_i,
  input  be_t   ld_mem_be_i,
  output logic  ld_mem_ack_o,
  output word_t ld_mem_rdata_o,
  // store path
  input  logic  st_mem_req_i,
  input  addr_t st_mem_addr_i,
  input  be_t   st_mem_be_i,
  input  word_t st_mem_wdata_i,
  output logic  st_mem_ack_o,
  // external memory port
  output logic  mem_req_o,
  output addr_t mem_addr_o,
  output logic  mem_we_o,
  output be_t   mem_be_o,
  output word_t mem_wdata_o,
  input  logic  mem_ack_i,
  input  word_t mem_rdata_i
);

  logic  gnt_ld_q;
  logic  gnt_st_q;
  logic  cur_req;
  addr_t sel_addr;

  assign cur_req = gnt_ld_q ? ld_mem_req_i : st_mem_req_i;

  // grant holds until the handshake has fully returned to zero
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_ld_q <= 1'b0;
      gnt_st_q <= 1'b0;
    end else if (!gnt_ld_q && !gnt_st_q) begin
      if (ld_mem_req_i) begin
        gnt_ld_q <= 1'b1;
      end else if (st_mem_req_i) begin
        gnt_st_q <= 1'b1;
      end
    end else if (!cur_req && !mem_ack_i) begin
      gnt_ld_q <= 1'b0;
      gnt_st_q <= 1'b0;
    end
  end

  // ------------------------------------------------------------
  // port mux
  // ------------------------------------------------------------
  assign sel_addr    = gnt_st_q ? st_mem_addr_i : ld_mem_addr_i;
  assign mem_addr_o  = {sel_addr[DataWidth-1:2], 2'b00};
  assign mem_req_o   = (gnt_ld_q & ld_mem_req_i) | (gnt_st_q & st_mem_req_i);
  assign mem_we_o    = gnt_st_q;
  assign mem_be_o    = gnt_st_q ? st_mem_be_i : ld_mem_be_i;
  assign mem_wdata_o = st_mem_wdata_i;

  assign ld_mem_ack_o   = gnt_ld_q & mem_ack_i;
  assign st_mem_ack_o   = gnt_st_q & mem_ack_i;
  assign ld_mem_rdata_o = mem_rdata_i;

endmodule

/* verification/mem_model.sv */
`timescale 1ns/1ns

module mem_model
  import lsu_pkg::*;
(
  input  logic       clk_i,
  input  logic [3:0] max_delay_i,
  input  logic       mem_req_i,
  input  addr_t      mem_addr_i,
  input  logic       mem_we_i,
  input  be_t        mem_be_i,
  input  word_t      mem_wdata_i,
  output logic       mem_ack_o,
  output word_t      mem_rdata_o,
  output logic       hang_o
);

  word_t       mem [256];
  logic [8:0]  fill_idx;
  logic [7:0]  idx;
  word_t       mask;
  int unsigned delay;
  int unsigned waited;

  initial begin
    mem_ack_o   = 1'b0;
    mem_rdata_o = '0;
    hang_o      = 1'b0;
    // every byte depends on the word index
    for (fill_idx = 9'd0; fill_idx < 9'd256; fill_idx++) begin
      idx           = fill_idx[7:0];
      mem[fill_idx[7:0]] = {idx ^ 8'ha5, ~idx, idx + 8'h3c, idx};
    end
    forever begin
      @(negedge clk_i);
      if (mem_req_i) begin
        delay = $urandom_range(0, {28'd0, max_delay_i});
        repeat (delay) @(negedge clk_i);
        idx = mem_addr_i[9:2];
        if (mem_we_i) begin
          mask = {{8{mem_be_i[3]}}, {8{mem_be_i[2]}}, {8{mem_be_i[1]}}, {8{mem_be_i[0]}}};
          mem[idx] = (mem[idx] & ~mask) | (mem_wdata_i & mask);
        end else begin
          mem_rdata_o = mem[idx];
        end
        mem_ack_o = 1'b1;
        // requester has to drop req before ack may fall
        waited = 0;
        while (mem_req_i && !hang_o) begin
          @(negedge clk_i);
          waited++;
          if (waited > 100) begin
            hang_o = 1'b1;
          end
        end
        delay = $urandom_range(0, {28'd0, max_delay_i});
        repeat (delay) @(negedge clk_i);
        mem_ack_o = 1'b0;
      end
    end
  end

endmodule

/* verification/tb_load_store_unit.sv */
`timescale 1ns/1ns

module tb_load_store_unit
  import lsu_pkg::*;
();

  localparam int unsigned Seed      = 32'h3195d037;
  localparam int unsigned WaitLimit = 4000;

  logic       clk_i;
  logic       rst_ni;
  logic       valid;
  logic       ready;
  lsu_op_e    op;
  word_t      operand_a;
  word_t      imm;
  word_t      wdata;
  trans_id_t  trans_id;
  logic       load_valid;
  trans_id_t  load_trans_id;
  word_t      load_result;
  logic       load_exc;
  exc_cause_t load_cause;
  logic       store_valid;
  trans_id_t  store_trans_id;
  logic       store_exc;
  exc_cause_t store_cause;
  logic       mem_req;
  addr_t      mem_addr;
  logic       mem_we;
  be_t        mem_be;
  word_t      mem_wdata;
  logic       mem_ack;
  word_t      mem_rdata;
  logic       mem_hang;
  logic [3:0] mem_delay_max;

  // shadow memory and expected results in issue order
  word_t       shadow [256];
  logic [8:0]  fill_idx;
  logic [39:0] ld_exp_q [$];
  logic [7:0]  st_exp_q [$];
  logic [39:0] ld_exp;
  logic [39:0] ld_act;
  logic [7:0]  st_exp;
  logic [7:0]  st_act;
  trans_id_t   next_id;
  lsu_op_e     cur_op;
  word_t       cur_addr;
  logic        no_mem;
  string       test_name;

  load_store_unit u_dut (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .valid_i         (valid),
    .ready_o         (ready),
    .op_i            (op),
    .operand_a_i     (operand_a),
    .imm_i           (imm),
    .wdata_i         (wdata),
    .trans_id_i      (trans_id),
    .load_valid_o    (load_valid),
    .load_trans_id_o (load_trans_id),
    .load_result_o   (load_result),
    .load_exc_o      (load_exc),
    .load_cause_o    (load_cause),
    .store_valid_o   (store_valid),
    .store_trans_id_o(store_trans_id),
    .store_exc_o     (store_exc),
    .store_cause_o   (store_cause),
    .mem_req_o       (mem_req),
    .mem_addr_o      (mem_addr),
    .mem_we_o        (mem_we),
    .mem_be_o        (mem_be),
    .mem_wdata_o     (mem_wdata),
    .mem_ack_i       (mem_ack),
    .mem_rdata_i     (mem_rdata)
  );

  mem_model u_mem (
    .clk_i      (clk_i),
    .max_delay_i(mem_delay_max),
    .mem_req_i  (mem_req),
    .mem_addr_i (mem_addr),
    .mem_we_i   (mem_we),
    .mem_be_i   (mem_be),
    .mem_wdata_i(mem_wdata),
    .mem_ack_o  (mem_ack),
    .mem_rdata_o(mem_rdata),
    .hang_o     (mem_hang)
  );

  initial begin
    clk_i = 1'b0;
    forever #2 clk_i = ~clk_i;
  end

  // ------------------------------------------------------------
  // helpers
  // ------------------------------------------------------------
  task automatic stop_with_error(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic report_mismatch(input string what, input logic [39:0] exp,
                                 input logic [39:0] act);
    stop_with_error($sformatf("MISMATCH %s %s expected=%h actual=%h",
                              test_name, what, exp, act));
  endtask

  function automatic word_t fill_word(input logic [7:0] idx);
    return {idx ^ 8'ha5, ~idx, idx + 8'h3c, idx};
  endfunction

  function automatic logic is_misaligned(input lsu_op_e m_op, input word_t addr);
    case (m_op)
      LH, LHU, SH: return addr[0];
      LW, SW:      return addr[1:0] != 2'b00;
      default:     return 1'b0;
    endcase
  endfunction

  function automatic word_t align_addr(input lsu_op_e a_op, input word_t addr);
    case (a_op)
      LH, LHU, SH: return {addr[31:1], 1'b0};
      LW, SW:      return {addr[31:2], 2'b00};
      default:     return addr;
    endcase
  endfunction

  // byte or half picked by the address, then sign or zero fill
  function automatic word_t extend_load(input lsu_op_e ld_op, input word_t addr,
                                        input word_t w);
    logic [7:0]  b;
    logic [15:0] h;
    b = w[{addr[1:0], 3'b000} +: 8];
    h = w[{addr[1], 4'b0000} +: 16];
    case (ld_op)
      LB:      return {{24{b[7]}}, b};
      LBU:     return {24'd0, b};
      LH:      return {{16{h[15]}}, h};
      LHU:     return {16'd0, h};
      default: return w;
    endcase
  endfunction

  function automatic void write_shadow(input lsu_op_e s_op, input word_t addr,
                                       input word_t data);
    case (s_op)
      SB:      shadow[addr[9:2]][{addr[1:0], 3'b000} +: 8] = data[7:0];
      SH:      shadow[addr[9:2]][{addr[1], 4'b0000} +: 16] = data[15:0];
      default: shadow[addr[9:2]] = data;
    endcase
  endfunction

  task automatic check_idle(input string what);
    assert ({ready, mem_req, load_valid, store_valid} == 4'b0000)
      else report_mismatch(what, 40'd0, {36'd0, ready, mem_req, load_valid, store_valid});
  endtask

  // called at a falling edge, returns at the falling edge after acceptance
  task automatic issue_request(input lsu_op_e req_op, input word_t addr, input word_t data);
    word_t       base;
    logic        mis;
    int unsigned waited;
    base      = $urandom();
    mis       = is_misaligned(req_op, addr);
    valid     = 1'b1;
    op        = req_op;
    operand_a = base;
    imm       = addr - base;
    wdata     = data;
    trans_id  = next_id;
    waited    = 0;
    while (!ready) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitLimit) stop_with_error("ready_o stayed low, request never taken");
    end
    if (req_op inside {SB, SH, SW}) begin
      if (mis) begin
        st_exp_q.push_back({next_id, 1'b1, CauseStMisaligned});
      end else begin
        st_exp_q.push_back({next_id, 1'b0, 4'd0});
        write_shadow(req_op, addr, data);
      end
    end else if (mis) begin
      ld_exp_q.push_back({next_id, 1'b1, CauseLdMisaligned, addr});
    end else begin
      ld_exp_q.push_back({next_id, 1'b0, 4'd0, extend_load(req_op, addr, shadow[addr[9:2]])});
    end
    next_id = next_id + 3'd1;
    @(negedge clk_i);
    valid = 1'b0;
  endtask

  task automatic wait_all_results();
    int unsigned waited;
    waited = 0;
    while (ld_exp_q.size() != 0 || st_exp_q.size() != 0) begin
      @(negedge clk_i);
      waited++;
      if (waited > WaitLimit) stop_with_error({test_name, ": results still missing"});
    end
  endtask

  // ------------------------------------------------------------
  // checkers
  // ------------------------------------------------------------
  req_held_until_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req && !mem_ack |=> mem_req)
    else stop_with_error("mem_req_o fell before mem_ack_i rose");

  no_req_rise_on_ack: assert property (@(posedge clk_i) disable iff (!rst_ni)
    $rose(mem_req) |-> !$past(mem_ack))
    else stop_with_error("mem_req_o rose while mem_ack_i was still high");

  req_fields_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    mem_req && $past(mem_req) |-> $stable(mem_addr) && $stable(mem_be) && $stable(mem_we)
      && (!mem_we || $stable(mem_wdata)))
    else stop_with_error("memory request fields changed while mem_req_o was high");

  always @(posedge clk_i) begin
    assert (mem_addr[1:0] == 2'b00) else stop_with_error("mem_addr_o is not word aligned");
    assert (!mem_hang) else stop_with_error("memory model saw mem_req_o stuck high");
    if (no_mem) begin
      assert (!mem_req) else stop_with_error("memory request during a misaligned access");
    end
    if (rst_ni && load_valid) begin
      assert (ld_exp_q.size() != 0) else stop_with_error("load result with no load pending");
      ld_exp = ld_exp_q.pop_front();
      ld_act = {load_trans_id, load_exc, load_cause, load_result};
      assert (ld_act == ld_exp) else report_mismatch("load", ld_exp, ld_act);
    end
    if (rst_ni && store_valid) begin
      assert (st_exp_q.size() != 0) else stop_with_error("store result with no store pending");
      st_exp = st_exp_q.pop_front();
      st_act = {store_trans_id, store_exc, store_cause};
      assert (st_act == st_exp) else report_mismatch("store", {32'd0, st_exp}, {32'd0, st_act});
    end
  end

  // ------------------------------------------------------------
  // stimulus
  // ------------------------------------------------------------
  initial begin
    void'($urandom(Seed));
    rst_ni        = 1'b0;
    valid         = 1'b0;
    op            = LW;
    operand_a     = '0;
    imm           = '0;
    wdata         = '0;
    trans_id      = '0;
    next_id       = '0;
    mem_delay_max = 4'd3;
    no_mem        = 1'b0;
    test_name     = "reset";
    for (fill_idx = 9'd0; fill_idx < 9'd256; fill_idx++) begin
      shadow[fill_idx[7:0]] = fill_word(fill_idx[7:0]);
    end

    repeat (10) begin
      @(negedge clk_i);
      check_idle("during_reset");
    end
    rst_ni = 1'b1;
    check_idle("after_reset");
    @(negedge clk_i);

    test_name = "aligned_loads";
    repeat (40) begin
      cur_op = lsu_op_e'(3'($urandom_range(0, 4)));
      issue_request(cur_op, align_addr(cur_op, $urandom_range(0, 1023)), 32'd0);
    end
    wait_all_results();

    // each store is read back by a full word load
    test_name = "store_merge";
    repeat (24) begin
      cur_op   = lsu_op_e'(3'($urandom_range(5, 7)));
      cur_addr = align_addr(cur_op, $urandom_range(0, 1023));
      issue_request(cur_op, cur_addr, $urandom());
      wait_all_results();
      issue_request(LW, {cur_addr[31:2], 2'b00}, 32'd0);
    end
    wait_all_results();

    test_name = "misaligned";
    no_mem    = 1'b1;
    repeat (16) begin
      cur_op = lsu_op_e'(3'($urandom_range(2, 7)));
      if (cur_op == SB) begin
        cur_op = SH;
      end
      cur_addr = $urandom_range(0, 1023);
      if (cur_op inside {LH, LHU, SH}) begin
        cur_addr[0] = 1'b1;
      end else begin
        cur_addr[1:0] = 2'($urandom_range(1, 3));
      end
      issue_request(cur_op, cur_addr, $urandom());
    end
    wait_all_results();
    @(negedge clk_i);
    no_mem = 1'b0;

    // loads in the lower half, stores in the upper half
    test_name     = "back_to_back";
    mem_delay_max = 4'd12;
    repeat (60) begin
      cur_op   = lsu_op_e'(3'($urandom_range(0, 7)));
      cur_addr = $urandom_range(0, 511);
      if (cur_op inside {SB, SH, SW}) begin
        cur_addr = cur_addr + 32'd512;
      end
      if ($urandom_range(0, 7) != 0) begin
        cur_addr = align_addr(cur_op, cur_addr);
      end
      issue_request(cur_op, cur_addr, $urandom());
    end
    wait_all_results();

    $display("TEST OK");
    $finish;
  end

endmodule
